/* Bender.yml */
package:
  name: riscv_pipeline

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpuPkg.sv
      - verilog/regFile.sv
      - verilog/fetchStage.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/memWbStage.sv
      - verilog/cpu.sv
  - target: simulation
    include_dirs:
      - verilog
      - verif
    files:
      - verif/tbClock.sv
      - verif/tbCpu.sv

/* filelist.f */
+incdir+verilog
+incdir+verif
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/cpu.sv
verif/tbClock.sv
verif/tbCpu.sv

/* verif/tbClock.sv */
/*
 * Testbench clock and reset source. 8 ns clock; reset is high for 4 cycles
 * at start and again for 4 cycles after each pulse on resetReq.
 */

`timescale 1ns/1ps
`default_nettype none

module tbClock
(
    input  logic resetReq,
    output logic clk,
    output logic rst
);

    int cnt = 4;

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
    end

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (resetReq)
        begin
            rst <= 1'b1;
            cnt <= 4;
        end
        else if (cnt > 0)
        begin
            cnt <= cnt - 1;
            if (cnt == 1)
                rst <= 1'b0; // last reset edge
        end
    end

endmodule : tbClock

`default_nettype wire

/* verif/cpuRefModel.svh */
/*
 * Instruction encoders and the ISA-level reference model of the testbench.
 * Included inside the testbench module; uses its prog, progLen and
 * expected-value queues.
 */

`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

// load, ALU op or jal with a destination other than x0
function automatic logic writesRegister(input logic [31:0] w);
    logic isWriter;
    isWriter = (w[6:0] == 7'h03) || (w[6:0] == 7'h13) || (w[6:0] == 7'h33)
               || (w[6:0] == 7'h6f);
    return isWriter && (w[11:7] != 5'd0);
endfunction

// runs prog[0..progLen-1] and queues every store and register write, in order
function automatic void modelProgram();
    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] pcAddr;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] alu;
    int          idx;
    int          steps;
    for (int i = 0; i < 32; i++)
        regs[i] = '0;
    for (int i = 0; i < 256; i++)
        mem[i] = '0;
    pcAddr = `RESET_PC;
    steps  = 0;
    while (steps < 4000)
    begin
        idx = (pcAddr - `RESET_PC) >> 2;
        if (idx >= progLen)
            break;
        w    = prog[idx];
        a    = regs[w[19:15]];
        b    = regs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        alu  = (w[6:0] == 7'h13) ? immI : b; // second operand
        pcAddr = pcAddr + 4;
        case (w[6:0])
            7'h03: regs[w[11:7]] = mem[(a + immI) >> 2 & 255];
            7'h23:
            begin
                expAddr.push_back(a + immS);
                expData.push_back(b);
                mem[(a + immS) >> 2 & 255] = b;
            end
            7'h13, 7'h33:
            begin
                case (w[14:12])
                    3'b000:  alu = (w[6:0] == 7'h33 && w[30]) ? a - alu : a + alu;
                    3'b010:  alu = ($signed(a) < $signed(alu)) ? 32'd1 : 32'd0;
                    3'b110:  alu = a | alu;
                    3'b111:  alu = a & alu;
                    default: alu = a + alu;
                endcase
                regs[w[11:7]] = alu;
            end
            7'h63: if (a == b) pcAddr = pcAddr - 4 + immB;
            7'h6f:
            begin
                regs[w[11:7]] = pcAddr;
                pcAddr = pcAddr - 4 + immJ;
            end
            default: ;
        endcase
        if (writesRegister(w))
            expWb.push_back(regs[w[11:7]]);
        regs[0] = '0;
        steps++;
    end
endfunction

`endif

/* verif/tbCpu.sv */
/*
 * Testbench of the pipelined core. Models instruction and data memory,
 * runs four programs and matches every store and register write
 * against the reference model.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tbCpu;

    localparam logic [31:0] NOP = 32'h0000_0013;

    logic             clk;
    logic             rst;
    logic             resetReq;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] readData;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] writeData;
    logic [`XLEN-1:0] result;
    logic             memWrite;
    logic [31:0]      imem [256];
    logic [31:0]      dmem [256];
    logic [31:0]      prog [256];
    int               progLen;
    logic [31:0]      expAddr [$];
    logic [31:0]      expData [$];
    logic [31:0]      expWb [$];
    logic [31:0]      inFlight [4];
    int               cycleCount = 0;
    int               cycleLimit = 0;
    integer           seed = 32'h089c_fa1d;
    logic [31:0]      pcOffset;

    `include "cpuRefModel.svh"

    tbClock i_clock (.resetReq(resetReq), .clk(clk), .rst(rst));

    cpu i_dut (
        .clk(clk), .rst(rst), .instr(instr), .readData(readData), .pc(pc),
        .aluResult(aluResult), .writeData(writeData), .memWrite(memWrite), .result(result)
    );

    assign pcOffset = pc - `RESET_PC;
    assign instr    = (pcOffset < 1024) ? imem[pcOffset[9:2]] : NOP;
    assign readData = dmem[aluResult[9:2]];

    always @(posedge clk)
        if (!rst && memWrite)
            dmem[aluResult[9:2]] <= writeData;

    task automatic stopRun();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stopRun();
        end
    endtask

    // store comparison
    always @(negedge clk)
    begin
        if (!rst && memWrite)
        begin
            if (expAddr.size() == 0)
            begin
                $display("unexpected store to address 0x%h", aluResult);
                stopRun();
            end
            else
            begin
                checkValue("aluResult", aluResult, expAddr.pop_front());
                checkValue("writeData", writeData, expData.pop_front());
            end
        end
    end

    // writeback comparison, the word fetched four cycles ago retires now
    always @(negedge clk)
    begin
        logic [31:0] retiring;
        retiring = inFlight[3];
        for (int i = 3; i > 0; i--)
            inFlight[i] = inFlight[i - 1];
        inFlight[0] = rst ? NOP : instr;
        if (!rst && writesRegister(retiring))
        begin
            if (expWb.size() == 0)
            begin
                $display("unexpected register write of 0x%h", result);
                stopRun();
            end
            else
                checkValue("result", result, expWb.pop_front());
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: %0d expected stores never appeared", expAddr.size());
            stopRun();
        end
    end

    // each instruction is followed by two nops, which keeps dependencies 3 apart
    task automatic put(input logic [31:0] w);
        prog[progLen]     = w;
        prog[progLen + 1] = NOP;
        prog[progLen + 2] = NOP;
        progLen += 3;
    endtask

    task automatic runProgram();
        cycleLimit += progLen + 40;
        @(posedge clk) resetReq <= 1'b1;
        @(posedge clk) resetReq <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = (i < progLen) ? prog[i] : NOP;
            dmem[i] = '0;
        end
        modelProgram();
        while (rst)
        begin
            checkValue("pc", pc, `RESET_PC);
            @(negedge clk);
        end
        checkValue("pc", pc, `RESET_PC);
        for (int i = 0; i < 3; i++)
        begin
            checkValue("memWrite", {31'b0, memWrite}, 32'd0);
            @(negedge clk);
        end
        while (expAddr.size() != 0)
            @(negedge clk);
        repeat (12) @(negedge clk); // catch extra stores
        if (expWb.size() != 0)
        begin
            $display("%0d expected register writes never appeared", expWb.size());
            stopRun();
        end
    endtask

    initial
    begin
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  kind;
        resetReq = 1'b0;

        // ALU operations
        progLen = 0;
        put(iType(12'd25, 0, 3'b000, 1, 7'h13));
        put(iType(-12'sd7, 0, 3'b000, 2, 7'h13));
        put(rType(7'h00, 2, 1, 3'b000, 3));
        put(rType(7'h20, 2, 1, 3'b000, 4));
        put(rType(7'h00, 2, 1, 3'b111, 5));
        put(rType(7'h00, 2, 1, 3'b110, 6));
        put(rType(7'h00, 1, 2, 3'b010, 7));  // negative < positive
        put(rType(7'h00, 2, 1, 3'b010, 8));
        put(iType(-12'sd3, 2, 3'b010, 9, 7'h13));
        put(iType(12'h700, 1, 3'b110, 10, 7'h13));
        put(iType(12'h0f0, 2, 3'b111, 11, 7'h13));
        put(iType(12'h800, 2, 3'b000, 12, 7'h13));
        for (int r = 3; r <= 12; r++)
            put(sType(12'h100 + 4 * r, r[4:0], 0));
        runProgram();

        // load and store, x0
        progLen = 0;
        put(iType(12'h5a5, 0, 3'b000, 1, 7'h13));
        put(sType(12'h200, 1, 0));
        put(iType(12'h200, 0, 3'b010, 2, 7'h03));
        put(iType(12'h011, 2, 3'b000, 3, 7'h13));
        put(sType(12'h204, 3, 0));
        put(iType(12'd77, 0, 3'b000, 0, 7'h13));
        put(sType(12'h208, 0, 0));
        put(iType(12'h1fc, 0, 3'b000, 4, 7'h13));
        put(iType(12'd4, 4, 3'b010, 5, 7'h03));
        put(sType(12'h20c, 5, 0));
        runProgram();

        // control flow, every slot is 12 bytes
        progLen = 0;
        put(iType(12'd5, 0, 3'b000, 1, 7'h13));
        put(iType(12'd5, 0, 3'b000, 2, 7'h13));
        put(iType(12'd6, 0, 3'b000, 3, 7'h13));
        put(bType(13'd24, 1, 2));           // taken
        put(sType(12'h3f0, 1, 0));           // skipped
        put(sType(12'h304, 2, 0));
        put(bType(13'd24, 1, 3));           // not taken
        put(sType(12'h300, 1, 0));
        put(jType(21'd24, 4));
        put(sType(12'h3f4, 2, 0));           // skipped
        put(sType(12'h308, 4, 0));
        runProgram();

        // random straight-line program
        progLen = 0;
        for (int r = 1; r <= 7; r++)
            put(iType($random(seed), 0, 3'b000, r[4:0], 7'h13));
        for (int n = 0; n < 20; n++)
        begin
            rd   = 1 + ($unsigned($random(seed)) % 7);
            rs1  = $unsigned($random(seed)) % 8;
            rs2  = $unsigned($random(seed)) % 8;
            kind = $unsigned($random(seed)) % 6;
            case (kind)
                3'd0:    put(iType($random(seed), rs1, 3'b000, rd, 7'h13));
                3'd1:    put(rType(7'h00, rs2, rs1, 3'b000, rd));
                3'd2:    put(rType(7'h20, rs2, rs1, 3'b000, rd));
                3'd3:    put(rType(7'h00, rs2, rs1, 3'b111, rd));
                3'd4:    put(rType(7'h00, rs2, rs1, 3'b110, rd));
                default: put(rType(7'h00, rs2, rs1, 3'b010, rd));
            endcase
        end
        for (int r = 1; r <= 7; r++)
            put(sType(12'h380 + 4 * r, r[4:0], 0));
        runProgram();

        $display("Simulation PASSED");
        $finish;
    end

endmodule : tbCpu

`default_nettype wire

/* verilog/cpu.sv */
/*
 * Top of the five-stage in-order RISC-V core.
 * Instruction and data memories sit outside; pc/instr and
 * aluResult/readData are combinational in the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu
    import cpuPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] readData,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] writeData,
    output logic             memWrite,
    output logic [`XLEN-1:0] result
);

    fetchBundle       fetchToDecode;
    execBundle        decodeToExec;
    memBundle         execToMem;
    regWriteBundle    wbToDecode;   // writeback loops back to the register file
    logic             pcSrc;
    logic [`XLEN-1:0] pcTarget;

    fetchStage i_fetch (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .pc       (pc),
        .fetchOut (fetchToDecode)
    );

    decodeStage i_decode (
        .clk     (clk),
        .rst     (rst),
        .fetchIn (fetchToDecode),
        .wbIn    (wbToDecode),
        .execOut (decodeToExec)
    );

    executeStage i_execute (
        .clk      (clk),
        .rst      (rst),
        .execIn   (decodeToExec),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .memOut   (execToMem)
    );

    memWbStage i_memWb (
        .clk       (clk),
        .rst       (rst),
        .memIn     (execToMem),
        .readData  (readData),
        .aluResult (aluResult),
        .writeData (writeData),
        .memWrite  (memWrite),
        .result    (result),
        .wbOut     (wbToDecode)
    );

endmodule : cpu

`default_nettype wire

/* verilog/cpuPkg.sv */
/*
 * Shared types of the pipelined core: decode enums and the packed
 * bundles that travel between pipeline stages.
 * Import into each stage module header.
 */

`default_nettype none

`include "cpu_params.svh"

package cpuPkg;

    typedef enum logic [6:0] {
        opLoad   = 7'd3,
        opIType  = 7'd19,
        opStore  = 7'd35,
        opRType  = 7'd51,
        opBranch = 7'd99,
        opJal    = 7'd111
    } opcode_e;

    // encodings match the original ALU
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOp_e;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrc_e;

    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrc_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] pcPlus4;
        logic [`XLEN-1:0] instr;
    } fetchBundle;

    typedef struct packed {
        logic       regWrite;
        resultSrc_e resultSrc;
        logic       memWrite;
        logic       jump;
        logic       branch;
        aluOp_e     aluControl;
        logic       aluSrc;     // 1 selects the immediate
    } ctrlBundle;

    typedef struct packed {
        logic [`XLEN-1:0]       rd1;
        logic [`XLEN-1:0]       rd2;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       pcPlus4;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
        ctrlBundle              ctrl;
    } execBundle;

    typedef struct packed {
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       writeData;
        logic [`XLEN-1:0]       pcPlus4;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   regWrite;
        resultSrc_e             resultSrc;
        logic                   memWrite;
    } memBundle;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } regWriteBundle;

endpackage : cpuPkg

`default_nettype wire

/* verilog/cpu_params.svh */
/*
 * Global sizing constants for the five-stage RISC-V core.
 * Included by the package, every pipeline stage and the testbench.
 */

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and address width
`define XLEN 32

// integer register file
`define NUM_REGS   32
`define REG_ADDR_W 5

`define RESET_PC 32'h0040_0000 // start of text segment

`endif

/* verilog/decodeStage.sv */
/*
 * Decode stage: main and ALU decoders, immediate extension,
 * register file reads, and the decode-to-execute register.
 * The writeback port from the last stage passes through to the register file.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decodeStage
    import cpuPkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  fetchBundle    fetchIn,
    input  regWriteBundle wbIn,
    output execBundle     execOut
);

    logic [`XLEN-1:0] instr;
    logic [2:0]       funct3;
    logic [1:0]       aluClass; // 00 mem, 01 branch, 10 arith
    immSrc_e          immSrc;
    ctrlBundle        ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;

    assign instr  = fetchIn.instr;
    assign funct3 = instr[14:12];

    function automatic aluOp_e aluDecode(input logic [1:0] cls, input logic [2:0] f3,
                                         input logic op5, input logic f7b5);
        aluOp_e op;
        op = aluAdd;
        if (cls == 2'b01)
            op = aluSub; // beq compares by subtraction
        else if (cls == 2'b10)
        begin
            case (f3)
                3'b000:  op = (op5 && f7b5) ? aluSub : aluAdd; // addi never subtracts
                3'b010:  op = aluSlt;
                3'b110:  op = aluOr;
                3'b111:  op = aluAnd;
                default: op = aluAdd;
            endcase
        end
        return op;
    endfunction

    // main decoder
    always_comb
    begin
        ctrl     = '0;
        immSrc   = immI;
        aluClass = 2'b00;
        case (opcode_e'(instr[6:0]))
            opLoad:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resMem;
                ctrl.aluSrc    = 1'b1;
            end
            opStore:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immSrc        = immS;
            end
            opRType:
            begin
                ctrl.regWrite = 1'b1;
                aluClass      = 2'b10;
            end
            opIType:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                aluClass      = 2'b10;
            end
            opBranch:
            begin
                ctrl.branch = 1'b1;
                immSrc      = immB;
                aluClass    = 2'b01;
            end
            opJal:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPcPlus4;
                ctrl.jump      = 1'b1;
                immSrc         = immJ;
            end
            default: ; // unknown opcode has no effect
        endcase
        ctrl.aluControl = aluDecode(aluClass, funct3, instr[5], instr[30]);
    end

    // sign-extended immediate
    always_comb
    begin
        case (immSrc)
            immS:    imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            immB:    imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            immJ:    imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        endcase
    end

    regFile i_regFile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (instr[19:15]),
        .raddr2 (instr[24:20]),
        .wr     (wbIn),
        .rdata1 (rd1),
        .rdata2 (rd2)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
            execOut <= '0;
        else
        begin
            execOut.rd1     <= rd1;
            execOut.rd2     <= rd2;
            execOut.pc      <= fetchIn.pc;
            execOut.pcPlus4 <= fetchIn.pcPlus4;
            execOut.imm     <= imm;
            execOut.rd      <= instr[11:7];
            execOut.ctrl    <= ctrl;
        end
    end

endmodule : decodeStage

`default_nettype wire

/* verilog/executeStage.sv */
/*
 * Execute stage: ALU, source-B select, branch target and redirect.
 * pcSrc and pcTarget go straight back to fetch in the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module executeStage
    import cpuPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  execBundle        execIn,
    output logic             pcSrc,
    output logic [`XLEN-1:0] pcTarget,
    output memBundle         memOut
);

    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic             zero;

    assign srcB = execIn.ctrl.aluSrc ? execIn.imm : execIn.rd2;

    always_comb
    begin
        case (execIn.ctrl.aluControl)
            aluSub:  aluResult = execIn.rd1 - srcB;
            aluAnd:  aluResult = execIn.rd1 & srcB;
            aluOr:   aluResult = execIn.rd1 | srcB;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, $signed(execIn.rd1) < $signed(srcB)};
            default: aluResult = execIn.rd1 + srcB;
        endcase
    end

    assign zero     = (aluResult == '0);
    assign pcTarget = execIn.pc + execIn.imm;
    assign pcSrc    = execIn.ctrl.jump || (execIn.ctrl.branch && zero); // beq taken on equal

    always_ff @(posedge clk)
    begin
        if (rst)
            memOut <= '0;
        else
        begin
            memOut.aluResult <= aluResult;
            memOut.writeData <= execIn.rd2;     // store data
            memOut.pcPlus4   <= execIn.pcPlus4; // jal link value
            memOut.rd        <= execIn.rd;
            memOut.regWrite  <= execIn.ctrl.regWrite;
            memOut.resultSrc <= execIn.ctrl.resultSrc;
            memOut.memWrite  <= execIn.ctrl.memWrite;
        end
    end

endmodule : executeStage

`default_nettype wire

/* verilog/fetchStage.sv */
/*
 * Fetch stage: program counter, next-PC select and the
 * fetch-to-decode register. A redirect from execute wins over PC+4.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetchStage
    import cpuPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] instr,
    input  logic             pcSrc,
    input  logic [`XLEN-1:0] pcTarget,
    output logic [`XLEN-1:0] pc,
    output fetchBundle       fetchOut
);

    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcNext;

    assign pcPlus4 = pc + `XLEN'd4;
    assign pcNext  = pcSrc ? pcTarget : pcPlus4; // taken beq or jal

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc       <= `RESET_PC;
            fetchOut <= '0; // zero instr decodes as no-op
        end
        else
        begin
            pc               <= pcNext;
            fetchOut.pc      <= pc;
            fetchOut.pcPlus4 <= pcPlus4;
            fetchOut.instr   <= instr;
        end
    end

endmodule : fetchStage

`default_nettype wire

/* verilog/memWbStage.sv */
/*
 * Memory and writeback stages. Presents the memory access at the top,
 * registers it into writeback and picks the value for the register file.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module memWbStage
    import cpuPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  memBundle         memIn,
    input  logic [`XLEN-1:0] readData,
    output logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] writeData,
    output logic             memWrite,
    output logic [`XLEN-1:0] result,
    output regWriteBundle    wbOut
);

    logic [`XLEN-1:0]       wbAluResult;
    logic [`XLEN-1:0]       wbReadData;
    logic [`XLEN-1:0]       wbPcPlus4;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic                   wbRegWrite;
    resultSrc_e             wbResultSrc;

    // memory stage drives the data memory directly
    assign aluResult = memIn.aluResult;
    assign writeData = memIn.writeData;
    assign memWrite  = memIn.memWrite;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbAluResult <= '0;
            wbReadData  <= '0;
            wbPcPlus4   <= '0;
            wbRd        <= '0;
            wbRegWrite  <= 1'b0;
            wbResultSrc <= resAlu;
        end
        else
        begin
            wbAluResult <= memIn.aluResult;
            wbReadData  <= readData;
            wbPcPlus4   <= memIn.pcPlus4;
            wbRd        <= memIn.rd;
            wbRegWrite  <= memIn.regWrite;
            wbResultSrc <= memIn.resultSrc;
        end
    end

    always_comb
    begin
        case (wbResultSrc)
            resMem:     result = wbReadData;
            resPcPlus4: result = wbPcPlus4;
            default:    result = wbAluResult;
        endcase
    end

    assign wbOut.en   = wbRegWrite;
    assign wbOut.addr = wbRd;
    assign wbOut.data = result;

endmodule : memWbStage

`default_nettype wire

/* verilog/regFile.sv */
/*
 * Integer register bank, 2 combinational reads and 1 write.
 * The write lands on the falling edge so decode sees it the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module regFile
    import cpuPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  regWriteBundle          wr,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(negedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr.en)
            regs[wr.addr] <= wr.data;
    end

    // x0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule : regFile

`default_nettype wire
